// ==== verilog/decim_settings.svh ====
// Fixed widths and coefficients of the decimate-by-4 receive chain
// Include this file wherever one of these values is needed
// Coefficients are signed with 11 fraction bits

`ifndef DECIM_SETTINGS_SVH
`define DECIM_SETTINGS_SVH

// Input samples and the requantized samples between the two stages
`define DECIM_SAMPLE_W 12

// Coefficient width in signed fixed point with 11 fraction bits
`define DECIM_COEFF_W 12

// Full-precision accumulator and stage output width
`define DECIM_ACC_W 26

// Unique coefficients of the symmetric six-tap filter
// This is also the number of MAC cycles in one run
`define DECIM_TAPS_HALF 3

// Coefficient values in units of 2^-11
`define DECIM_C0 213
`define DECIM_C1 1778
`define DECIM_C2 (-962)

// Fraction bits that the requantizer drops between the stages
`define DECIM_FRAC_BITS 11

`endif

// ==== verilog/decim_pkg.sv ====
// Shared types of the decimation chain
// Modules refer to these by scoped names, the widths come from the settings header

`default_nettype none

`include "decim_settings.svh"

package decim_pkg;

  // One signed input sample, also used for the requantized stage-one result
  typedef logic signed [`DECIM_SAMPLE_W-1:0] sample_t;

  // One signed filter coefficient
  typedef logic signed [`DECIM_COEFF_W-1:0] coeff_t;

  // Full-precision sum of one output
  typedef logic signed [`DECIM_ACC_W-1:0] acc_t;

  // Sequencer states of one MAC run
  // Idle waits for the odd-phase strobe, run steps the taps and drain
  // lets the pipeline empty until the result is ready
  typedef enum logic [1:0] {
    mac_idle,
    mac_run,
    mac_drain
  } mac_state_e;

endpackage

`default_nettype wire

// ==== verilog/fir_decim_ctrl.sv ====
// Phase and tap sequencer of one decimate-by-two stage
// Every second accepted strobe starts a three-cycle MAC run
// The load, multiply and accumulate enables follow one cycle apart and
// ready marks the cycle in which the accumulator holds the finished sum

`timescale 1ns/10ps
`default_nettype none

`include "decim_settings.svh"

module fir_decim_ctrl (
  input  logic       clk,
  input  logic       reset,
  input  logic       clk_enable,
  output logic       phase,
  output logic [1:0] tap,
  output logic       mac_load,
  output logic       mac_mult,
  output logic       mac_acc,
  output logic       ready
);

  // Last tap index of a run
  localparam logic [1:0] TAP_LAST = 2'(`DECIM_TAPS_HALF - 1);

  decim_pkg::mac_state_e state;
  decim_pkg::mac_state_e state_next;
  logic start;

  // A run begins on a strobe that lands in the odd phase
  assign start = clk_enable && phase;

  // Phase is 1 out of reset, so the first sample goes to the odd history
  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= 1'b1;
    end else if (clk_enable) begin
      phase <= ~phase;
    end
  end

  // **********************************************************************
  // Run sequencer
  // **********************************************************************

  always_comb begin
    state_next = state;
    case (state)
      decim_pkg::mac_idle: begin
        if (start) begin
          state_next = decim_pkg::mac_run;
        end
      end
      decim_pkg::mac_run: begin
        if (tap == TAP_LAST) begin
          state_next = decim_pkg::mac_drain;
        end
      end
      decim_pkg::mac_drain: begin
        // Back to idle once the result has been handed over
        if (ready) begin
          state_next = decim_pkg::mac_idle;
        end
      end
      default: state_next = decim_pkg::mac_idle;
    endcase
  end

  // The tap counter only moves while running and rests at zero otherwise
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= decim_pkg::mac_idle;
      tap   <= 2'd0;
    end else begin
      state <= state_next;
      if (state == decim_pkg::mac_run && tap != TAP_LAST) begin
        tap <= tap + 2'd1;
      end else begin
        tap <= 2'd0;
      end
    end
  end

  // Pre-adder stage is enabled while the run lasts
  assign mac_load = (state == decim_pkg::mac_run);

  // Multiplier and accumulator enables trail by one and two cycles
  // Ready is the registered falling edge of the accumulate enable
  always_ff @(posedge clk) begin
    if (reset) begin
      mac_mult <= 1'b0;
      mac_acc  <= 1'b0;
      ready    <= 1'b0;
    end else begin
      mac_mult <= mac_load;
      mac_acc  <= mac_mult;
      ready    <= mac_acc && !mac_mult;
    end
  end

  // Strobes closer than five cycles would overrun the shared MAC path
  strobe_spacing: assert property (@(posedge clk) disable iff (reset)
    clk_enable |=> !clk_enable [*4])
    else $error("clk_enable strobes closer than five cycles");

  // A run hands its sum over six cycles after the strobe that started it
  ready_after_start: assert property (@(posedge clk) disable iff (reset)
    start |-> ##6 ready)
    else $error("ready did not follow a run start by six cycles");

endmodule

`default_nettype wire

// ==== verilog/fir_decim_mac.sv ====
// Time-shared pre-add, multiply and accumulate path of one FIR stage
// Each tap pair passes through three register stages, and the sum is
// cleared by the result pulse so that the next run starts from zero

`timescale 1ns/10ps
`default_nettype none

`include "decim_settings.svh"

module fir_decim_mac (
  input  logic               clk,
  input  logic               reset,
  input  logic               mac_load,
  input  logic               mac_mult,
  input  logic               mac_acc,
  input  logic               clear,
  input  decim_pkg::sample_t even_tap,
  input  decim_pkg::sample_t odd_tap,
  input  decim_pkg::coeff_t  coeff,
  output decim_pkg::acc_t    sum
);

  // One guard bit for the pre-add of two samples
  localparam int PRE_W = `DECIM_SAMPLE_W + 1;

  // The largest coefficient magnitude is below 2^11, so the product of a
  // 13-bit pre-sum and a coefficient fits in 24 bits
  localparam int PROD_W = `DECIM_SAMPLE_W + `DECIM_COEFF_W;

  logic signed [PRE_W-1:0]  pre_sum;
  decim_pkg::coeff_t        coeff_q;
  logic signed [PROD_W-1:0] product;

  // **********************************************************************
  // Pipeline registers
  // **********************************************************************

  // Pre-adder stage, the coefficient is delayed alongside the pair
  always_ff @(posedge clk) begin
    if (mac_load) begin
      pre_sum <= PRE_W'(even_tap) + PRE_W'(odd_tap);
      coeff_q <= coeff;
    end
  end

  // Multiplier stage
  always_ff @(posedge clk) begin
    if (mac_mult) begin
      product <= PROD_W'(pre_sum) * PROD_W'(coeff_q);
    end
  end

  // Accumulator stage
  // Clear wins over accumulate so that two runs never mix
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      sum <= '0;
    end else if (mac_acc) begin
      sum <= sum + decim_pkg::acc_t'(product);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fir_decim.sv ====
// One decimate-by-two stage of the receive chain
// Samples arrive as single-cycle clk_enable strobes, at least five cycles
// apart, and every second strobe produces one full-precision output
// with a one-cycle ce_out pulse, seven cycles after that strobe

`timescale 1ns/10ps
`default_nettype none

`include "decim_settings.svh"

module fir_decim (
  input  logic               clk,
  input  logic               reset,
  input  logic               clk_enable,
  input  decim_pkg::sample_t filter_in,
  output decim_pkg::acc_t    filter_out,
  output logic               ce_out
);

  localparam int SAMPLE_W = `DECIM_SAMPLE_W;

  // Each phase keeps its newest samples in bit-column shift registers
  localparam int HIST_DEPTH = 4;

  localparam logic [1:0] TAP_LAST = 2'(`DECIM_TAPS_HALF - 1);

  // Bit 0 of every column holds the newest sample of that phase
  logic [HIST_DEPTH-1:0] even_hist [SAMPLE_W];
  logic [HIST_DEPTH-1:0] odd_hist  [SAMPLE_W];

  logic               phase;
  logic [1:0]         tap;
  logic               mac_load;
  logic               mac_mult;
  logic               mac_acc;
  logic               ready;
  decim_pkg::sample_t even_tap;
  decim_pkg::sample_t odd_tap;
  decim_pkg::coeff_t  coeff;
  decim_pkg::acc_t    sum;

  // **********************************************************************
  // Sample history
  // **********************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int b = 0; b < SAMPLE_W; b++) begin
        even_hist[b] <= '0;
        odd_hist[b]  <= '0;
      end
    end else if (clk_enable) begin
      for (int b = 0; b < SAMPLE_W; b++) begin
        if (phase) begin
          odd_hist[b] <= {odd_hist[b][HIST_DEPTH-2:0], filter_in[b]};
        end else begin
          even_hist[b] <= {even_hist[b][HIST_DEPTH-2:0], filter_in[b]};
        end
      end
    end
  end

  // Even samples are read oldest first and odd samples newest first,
  // so each tap picks up one symmetric pair of the six-sample window
  always_comb begin
    for (int b = 0; b < SAMPLE_W; b++) begin
      even_tap[b] = even_hist[b][TAP_LAST - tap];
      odd_tap[b]  = odd_hist[b][tap];
    end
  end

  // Tap 1 carries the middle pair and tap 2 the inner outer pair,
  // which is why C2 and C1 swap places here
  always_comb begin
    case (tap)
      2'd0:    coeff = decim_pkg::coeff_t'(`DECIM_C0);
      2'd1:    coeff = decim_pkg::coeff_t'(`DECIM_C2);
      2'd2:    coeff = decim_pkg::coeff_t'(`DECIM_C1);
      default: coeff = '0;
    endcase
  end

  // **********************************************************************
  // Sequencer and MAC
  // **********************************************************************

  fir_decim_ctrl ctrl (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .phase      (phase),
    .tap        (tap),
    .mac_load   (mac_load),
    .mac_mult   (mac_mult),
    .mac_acc    (mac_acc),
    .ready      (ready)
  );

  fir_decim_mac mac (
    .clk      (clk),
    .reset    (reset),
    .mac_load (mac_load),
    .mac_mult (mac_mult),
    .mac_acc  (mac_acc),
    .clear    (ready),
    .even_tap (even_tap),
    .odd_tap  (odd_tap),
    .coeff    (coeff),
    .sum      (sum)
  );

  // Result holds between pulses
  always_ff @(posedge clk) begin
    if (ready) begin
      filter_out <= sum;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ce_out <= 1'b0;
    end else begin
      ce_out <= ready;
    end
  end

  // Two outputs are always at least ten cycles apart
  single_ce: assert property (@(posedge clk) disable iff (reset)
    ce_out |=> !ce_out [*9])
    else $error("ce_out pulses closer than ten cycles");

endmodule

`default_nettype wire

// ==== verilog/sample_requant.sv ====
// Requantizer between the two decimation stages
// Rounds half up, drops FRAC_BITS fraction bits and clamps the result to
// the sample range, with the result registered one cycle after in_valid
// and sat marking every sample that had to be clipped

`timescale 1ns/10ps
`default_nettype none

`include "decim_settings.svh"

module sample_requant #(
  parameter int FRAC_BITS = `DECIM_FRAC_BITS
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  input  decim_pkg::acc_t    in_value,
  output logic               out_valid,
  output logic               sat,
  output decim_pkg::sample_t out_value
);

  // One extra bit keeps the rounding add from wrapping
  localparam int WIDE_W  = `DECIM_ACC_W + 1;
  localparam int SHIFT_W = WIDE_W - FRAC_BITS;

  localparam logic signed [WIDE_W-1:0] HALF_LSB = WIDE_W'(1) <<< (FRAC_BITS - 1);
  localparam logic signed [SHIFT_W-1:0] MAX_VAL =
    (SHIFT_W'(1) <<< (`DECIM_SAMPLE_W - 1)) - SHIFT_W'(1);
  localparam logic signed [SHIFT_W-1:0] MIN_VAL = -(SHIFT_W'(1) <<< (`DECIM_SAMPLE_W - 1));

  logic signed [WIDE_W-1:0]  rounded;
  logic signed [SHIFT_W-1:0] shifted;
  logic                      clip_hi;
  logic                      clip_lo;

  assign rounded = WIDE_W'(in_value) + HALF_LSB;
  assign shifted = rounded[WIDE_W-1:FRAC_BITS];
  assign clip_hi = shifted > MAX_VAL;
  assign clip_lo = shifted < MIN_VAL;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      sat       <= 1'b0;
    end else begin
      out_valid <= in_valid;
      sat       <= in_valid && (clip_hi || clip_lo);
    end
  end

  // The sample itself only changes with a new input
  always_ff @(posedge clk) begin
    if (in_valid) begin
      if (clip_hi) begin
        out_value <= decim_pkg::sample_t'(MAX_VAL);
      end else if (clip_lo) begin
        out_value <= decim_pkg::sample_t'(MIN_VAL);
      end else begin
        out_value <= decim_pkg::sample_t'(shifted);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/decim_chain.sv ====
// Top level of the decimate-by-4 receive filter chain
// Stage one halves the rate of sample_in, the requantizer brings its
// result back to sample width and stage two halves the rate again
// Both the half-rate and the quarter-rate results are brought out

`timescale 1ns/10ps
`default_nettype none

module decim_chain (
  input  logic               clk,
  input  logic               reset,
  input  logic               sample_valid,
  input  decim_pkg::sample_t sample_in,
  output decim_pkg::acc_t    half_out,
  output logic               half_valid,
  output decim_pkg::acc_t    quarter_out,
  output logic               quarter_valid,
  output logic               sat
);

  // Requantized half-rate samples feeding stage two
  decim_pkg::sample_t requant_value;
  logic               requant_valid;

  // **********************************************************************
  // First stage
  // **********************************************************************

  // Every second input strobe gives a half_valid pulse seven cycles later
  fir_decim stage_one (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (sample_valid),
    .filter_in  (sample_in),
    .filter_out (half_out),
    .ce_out     (half_valid)
  );

  // **********************************************************************
  // Requantizer
  // **********************************************************************

  // Adds one cycle between half_valid and the stage-two strobe
  sample_requant requant (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (half_valid),
    .in_value  (half_out),
    .out_valid (requant_valid),
    .sat       (sat),
    .out_value (requant_value)
  );

  // **********************************************************************
  // Second stage
  // **********************************************************************

  // Its strobes are at least ten cycles apart, well inside the stage limit
  fir_decim stage_two (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (requant_valid),
    .filter_in  (requant_value),
    .filter_out (quarter_out),
    .ce_out     (quarter_valid)
  );

endmodule

`default_nettype wire

// ==== tests/tb_decim_chain.sv ====
// Testbench for the decimate-by-4 receive filter chain
// Drives strobed samples into decim_chain and checks the half-rate and
// quarter-rate results and the sat flag against a model of the filter rule
// Run it through run_sim.sh, which builds it from filelist.f

`timescale 1ns/10ps
`default_nettype none

`include "decim_settings.svh"

module tb_decim_chain;

  localparam int N_IMPULSE = 24;
  localparam int N_RANDOM  = 400;
  localparam int N_SAT     = 48;
  localparam int N_MIN     = 48;
  localparam int N_RESET   = 32;

  // Every sample at the widest gap of 8 cycles, plus room for resets and drains
  localparam int STIM_CYCLES = (N_IMPULSE + N_RANDOM + N_SAT + N_MIN + N_RESET) * 8 + 200;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

  localparam longint SAMPLE_MAX = (longint'(1) <<< (`DECIM_SAMPLE_W - 1)) - 1;
  localparam longint SAMPLE_MIN = -(longint'(1) <<< (`DECIM_SAMPLE_W - 1));

  logic               clk;
  logic               reset;
  logic               sample_valid;
  decim_pkg::sample_t sample_in;
  decim_pkg::acc_t    half_out;
  logic               half_valid;
  decim_pkg::acc_t    quarter_out;
  logic               quarter_valid;
  logic               sat;

  // Model state of both stages, x0 is the oldest entry and x5 the newest
  logic [31:0] lfsr_state;
  longint      hist1 [6];
  longint      hist2 [6];
  logic        phase1;
  logic        phase2;

  // Expected results in output order
  longint half_q [$];
  longint quarter_q [$];
  bit     sat_q [$];

  int   half_seen;
  int   quarter_seen;
  int   sat_seen;
  bit   sat_due;
  bit   sat_expect;
  logic rst_applied = 1'b1;
  int   cycle_count = 0;

  decim_chain uut (
    .clk           (clk),
    .reset         (reset),
    .sample_valid  (sample_valid),
    .sample_in     (sample_in),
    .half_out      (half_out),
    .half_valid    (half_valid),
    .quarter_out   (quarter_out),
    .quarter_valid (quarter_valid),
    .sat           (sat)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // **********************************************************************
  // Checking helpers
  // **********************************************************************

  task automatic check_value(input string name, input longint got, input longint expected);
    if (got !== expected) begin
      $display("Error: %s is %h, expected %h", name, got, expected);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at the first failure");
  endtask

  // **********************************************************************
  // Stimulus source and reference model
  // **********************************************************************

  // Galois LFSR, one step per bit handed out
  function automatic bit lfsr_bit();
    bit out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Symmetric six-tap rule, full precision
  function automatic longint ref_fir(input longint x0, input longint x1, input longint x2,
                                     input longint x3, input longint x4, input longint x5);
    return `DECIM_C0 * (x0 + x5) + `DECIM_C1 * (x1 + x4) + `DECIM_C2 * (x2 + x3);
  endfunction

  // Round half up and drop the fraction bits, before any clamping
  function automatic longint rounded_of(input longint v);
    return (v + (longint'(1) <<< (`DECIM_FRAC_BITS - 1))) >>> `DECIM_FRAC_BITS;
  endfunction

  function automatic longint requant_of(input longint v);
    longint r;
    r = rounded_of(v);
    if (r > SAMPLE_MAX) begin
      r = SAMPLE_MAX;
    end else if (r < SAMPLE_MIN) begin
      r = SAMPLE_MIN;
    end
    return r;
  endfunction

  function automatic void clear_models();
    for (int i = 0; i < 6; i++) begin
      hist1[i] = 0;
      hist2[i] = 0;
    end
    phase1 = 1'b1;
    phase2 = 1'b1;
  endfunction

  // Each strobe in the odd phase closes a window and yields one result,
  // and every half-rate result feeds stage two after requantizing
  function automatic void model_accept(input longint value);
    longint half;
    longint q;
    for (int i = 0; i < 5; i++) begin
      hist1[i] = hist1[i + 1];
    end
    hist1[5] = value;
    if (phase1) begin
      half = ref_fir(hist1[0], hist1[1], hist1[2], hist1[3], hist1[4], hist1[5]);
      half_q.push_back(half);
      sat_q.push_back(rounded_of(half) > SAMPLE_MAX || rounded_of(half) < SAMPLE_MIN);
      q = requant_of(half);
      for (int i = 0; i < 5; i++) begin
        hist2[i] = hist2[i + 1];
      end
      hist2[5] = q;
      if (phase2) begin
        quarter_q.push_back(ref_fir(hist2[0], hist2[1], hist2[2], hist2[3], hist2[4], hist2[5]));
      end
      phase2 = !phase2;
    end
    phase1 = !phase1;
  endfunction

  // **********************************************************************
  // Drivers, all called and returning 1 ns after a rising edge
  // **********************************************************************

  task automatic send_sample(input decim_pkg::sample_t value, input int gap);
    sample_in = value;
    sample_valid = 1'b1;
    model_accept(longint'(value));
    @(posedge clk);
    #1;
    sample_valid = 1'b0;
    repeat (gap - 1) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Results still in flight are lost in the DUT, so they leave the queues too
  task automatic apply_reset(input int cycles);
    reset = 1'b1;
    repeat (cycles) @(posedge clk);
    #1;
    half_q.delete();
    quarter_q.delete();
    sat_q.delete();
    clear_models();
    reset = 1'b0;
  endtask

  task automatic wait_drained();
    while (half_q.size() != 0 || quarter_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    #1;
  endtask

  // **********************************************************************
  // Compare process
  // **********************************************************************

  // Reset as the DUT registers saw it at the last edge
  always @(posedge clk) begin
    rst_applied <= reset;
  end

  // Sampled mid-cycle, where every registered output is settled
  always @(negedge clk) begin
    if (rst_applied) begin
      check_value("half_valid", half_valid, 0);
      check_value("quarter_valid", quarter_valid, 0);
      check_value("sat", sat, 0);
      sat_due = 1'b0;
    end else begin
      // sat belongs to the half-rate result of the previous cycle
      check_value("sat", sat, sat_due ? sat_expect : 1'b0);
      if (sat) begin
        sat_seen++;
      end
      sat_due = 1'b0;
      if (half_valid) begin
        if (half_q.size() == 0) begin
          report_failure("A half_valid pulse came with no result expected");
        end else begin
          check_value("half_out", half_out, half_q.pop_front());
          sat_expect = sat_q.pop_front();
          sat_due = 1'b1;
          half_seen++;
        end
      end
      if (quarter_valid) begin
        if (quarter_q.size() == 0) begin
          report_failure("A quarter_valid pulse came with no result expected");
        end else begin
          check_value("quarter_out", quarter_out, quarter_q.pop_front());
          quarter_seen++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, results are still missing", cycle_count);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  // **********************************************************************
  // Test sequence
  // **********************************************************************

  initial begin
    decim_pkg::sample_t value;
    int                 gap;
    int                 h_start;
    int                 q_start;
    int                 s_start;
    reset = 1'b1;
    sample_valid = 1'b0;
    sample_in = '0;
    lfsr_state = 32'h48da;
    half_seen = 0;
    quarter_seen = 0;
    sat_seen = 0;
    sat_due = 1'b0;
    sat_expect = 1'b0;
    clear_models();
    apply_reset(10);

    // Impulse at an odd position, then one at an even position
    send_sample(decim_pkg::sample_t'(2047), 6);
    repeat (11) send_sample('0, 6);
    send_sample('0, 6);
    send_sample(decim_pkg::sample_t'(2047), 6);
    repeat (10) send_sample('0, 6);
    wait_drained();

    // Random data with random legal spacing, one output per two inputs
    h_start = half_seen;
    q_start = quarter_seen;
    for (int i = 0; i < N_RANDOM; i++) begin
      value = decim_pkg::sample_t'(rand_bits(`DECIM_SAMPLE_W));
      gap = 5 + int'(rand_bits(2));
      send_sample(value, gap);
    end
    wait_drained();
    check_value("half_valid count", half_seen - h_start, N_RANDOM / 2);
    check_value("quarter_valid count", quarter_seen - q_start, N_RANDOM / 4);

    // Full-scale pairs of alternating sign, offset by one sample so that
    // every output window lines up with the coefficient signs
    s_start = sat_seen;
    for (int i = 0; i < N_SAT; i++) begin
      value = (((i + 1) / 2) % 2 == 0) ? decim_pkg::sample_t'(2047)
                                       : decim_pkg::sample_t'(-2048);
      send_sample(value, 5);
    end
    wait_drained();
    check_value("sat pulses seen", sat_seen > s_start, 1);

    // Back-to-back runs at the minimum spacing
    h_start = half_seen;
    for (int i = 0; i < N_MIN; i++) begin
      value = decim_pkg::sample_t'(rand_bits(`DECIM_SAMPLE_W));
      send_sample(value, 5);
    end
    wait_drained();
    check_value("half_valid count", half_seen - h_start, N_MIN / 2);

    // Reset lands two cycles after a strobe that started a run
    for (int i = 0; i < 8; i++) begin
      send_sample(decim_pkg::sample_t'(rand_bits(`DECIM_SAMPLE_W)), 6);
    end
    if (!phase1) begin
      send_sample(decim_pkg::sample_t'(rand_bits(`DECIM_SAMPLE_W)), 6);
    end
    send_sample(decim_pkg::sample_t'(rand_bits(`DECIM_SAMPLE_W)), 2);
    apply_reset(4);
    for (int i = 0; i < N_RESET - 10; i++) begin
      value = decim_pkg::sample_t'(rand_bits(`DECIM_SAMPLE_W));
      gap = 5 + int'(rand_bits(2));
      send_sample(value, gap);
    end
    wait_drained();

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+verilog
verilog/decim_pkg.sv
verilog/fir_decim_ctrl.sv
verilog/fir_decim_mac.sv
verilog/fir_decim.sv
verilog/sample_requant.sv
verilog/decim_chain.sv
tests/tb_decim_chain.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the decimate-by-4 chain testbench with Verilator and runs it.
# The verdict comes from the pass line in sim.log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/10ps \
  --top-module tb_decim_chain \
  -f filelist.f \
  -o tb_decim_chain

status=0
./obj_dir/tb_decim_chain > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "RESULT: PASS" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, exit status $status"
exit 1
